// ==== cfg_pkg.sv ====
package cfg_pkg;

    //////////////////////////////
    // frame geometry
    //////////////////////////////

    // words in one configuration frame
    localparam int WORDS_PER_FRAME = 101;
    // most frames per operation
    localparam int MAX_FRAMES = 4;
    // frame buffer size and address width
    localparam int BUF_DEPTH = 512;
    localparam int BUF_ADDR_W = 9;
    // word index inside a frame
    localparam int WORD_IDX_W = 7;
    // bit location is word index * 32 + bit number
    localparam int BIT_LOC_W = 12;
    // request to returned word, in cycles
    localparam int CFG_READ_LATENCY = 2;

    //////////////////////////////
    // operation codes
    //////////////////////////////

    // code 0 left unused, treated as no command
    localparam logic [1:0] OP_READ = 2'd1;
    localparam logic [1:0] OP_WRITE = 2'd2;
    localparam logic [1:0] OP_FLIP = 2'd3;

    //////////////////////////////
    // bus payloads
    //////////////////////////////

    typedef logic [31:0] cfg_word_t;

    // one word request on the config port
    typedef struct packed {
        logic valid;
        logic write;
        logic [31:0] frame_addr;
        logic [WORD_IDX_W-1:0] word_idx;
        cfg_word_t data;
    } cfg_req_t;

    // read return, fixed latency after the request
    typedef struct packed {
        logic valid;
        cfg_word_t data;
    } cfg_rsp_t;

    // frame buffer write port
    typedef struct packed {
        logic en;
        logic [BUF_ADDR_W-1:0] addr;
        cfg_word_t data;
    } buf_wr_t;

    // operation command, sampled on start
    typedef struct packed {
        logic [1:0] op;
        logic [31:0] frame_addr;
        logic [2:0] num_frames;
        logic [BIT_LOC_W-1:0] bit_loc;
    } op_cmd_t;

endpackage

// ==== frame_reader.sv ====
`timescale 1ns/1ps

module frame_reader import cfg_pkg::*; (
    input  logic                Clk,
    input  logic                arst_n,
    input  logic                rd_start,
    input  cfg_word_t           frame_addr,
    input  logic [2:0]          num_frames,
    input  cfg_rsp_t            cfg_rsp,
    output cfg_req_t            req,
    output buf_wr_t             buf_wr,
    output logic                rd_done
);

    // request side
    logic                  issuing;
    cfg_word_t             base;
    logic [2:0]            nframes;
    logic [2:0]            q_frame;
    logic [WORD_IDX_W-1:0] q_word;
    logic                  q_last;
    // return side, one extra bit to catch overrun
    logic [BUF_ADDR_W:0]   wr_ptr;
    logic [BUF_ADDR_W:0]   words_left;

    //////////////////////////////
    // read requests
    //////////////////////////////

    // last word of the last frame
    assign q_last = (q_word == WORD_IDX_W'(WORDS_PER_FRAME - 1)) && (q_frame == nframes - 3'd1);

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            issuing <= 1'b0;
            q_frame <= '0;
            q_word <= '0;
        end
        else if (rd_start)
        begin
            issuing <= 1'b1;
            q_frame <= '0;
            q_word <= '0;
        end
        else if (issuing)
        begin
            if (q_last)
            begin
                // counters back to zero for the next run
                issuing <= 1'b0;
                q_frame <= '0;
                q_word <= '0;
            end
            else if (q_word == WORD_IDX_W'(WORDS_PER_FRAME - 1))
            begin
                q_word <= '0;
                q_frame <= q_frame + 3'd1;
            end
            else
                q_word <= q_word + 1'b1;
        end
    end

    // run parameters
    always_ff @(posedge Clk)
    begin
        if (rd_start)
        begin
            base <= frame_addr;
            nframes <= num_frames;
        end
    end

    // one read per cycle while issuing
    always_comb
    begin
        req = '0;
        req.valid = issuing;
        req.write = 1'b0;
        req.frame_addr = base + cfg_word_t'(q_frame);
        req.word_idx = q_word;
    end

    //////////////////////////////
    // returned words
    //////////////////////////////

    // frames sit back to back, so the pointer equals frame * 101 + word
    assign buf_wr.en = cfg_rsp.valid && (words_left != '0);
    assign buf_wr.addr = wr_ptr[BUF_ADDR_W-1:0];
    assign buf_wr.data = cfg_rsp.data;

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            words_left <= '0;
            rd_done <= 1'b0;
        end
        else
        begin
            // done one cycle after the last buffer write
            rd_done <= buf_wr.en && (words_left == (BUF_ADDR_W+1)'(1));
            if (rd_start)
            begin
                wr_ptr <= '0;
                words_left <= (BUF_ADDR_W+1)'(num_frames * WORDS_PER_FRAME);
            end
            else if (buf_wr.en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
                words_left <= words_left - 1'b1;
            end
        end
    end

    // buffer address must never wrap past the memory
    a_buf_addr_range: assert property (@(posedge Clk) disable iff (!arst_n)
        buf_wr.en |-> (wr_ptr < (BUF_ADDR_W+1)'(BUF_DEPTH)));

endmodule

// ==== frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer import cfg_pkg::*; (
    input  logic                  Clk,
    input  buf_wr_t               wr,
    input  logic [BUF_ADDR_W-1:0] rd_addr,
    output cfg_word_t             rd_data
);

    //////////////////////////////
    // storage
    //////////////////////////////

    // holds up to MAX_FRAMES frames back to back
    cfg_word_t mem [BUF_DEPTH];

    // write port, reader or flip write
    always_ff @(posedge Clk)
    begin
        if (wr.en)
        begin
            mem[wr.addr] <= wr.data;
        end
    end

    //////////////////////////////
    // registered read
    //////////////////////////////

    // one cycle from address to data
    // read during write to the same address returns the old word
    always_ff @(posedge Clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== frame_writer.sv ====
`timescale 1ns/1ps

module frame_writer import cfg_pkg::*; (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  logic                  wr_start,
    input  cfg_word_t             frame_addr,
    input  logic [2:0]            num_frames,
    output logic [BUF_ADDR_W-1:0] rd_addr,
    input  cfg_word_t             rd_data,
    output cfg_req_t              req,
    output logic                  wr_done
);

    // fetch stage
    logic                  fetching;
    logic                  fetch_en;
    logic                  f_last;
    logic [2:0]            nframes_eff;
    logic [BUF_ADDR_W-1:0] rd_ptr;
    logic [2:0]            f_frame;
    logic [WORD_IDX_W-1:0] f_word;
    // issue stage, one behind to match buffer latency
    logic                  iss_valid;
    logic                  iss_last;
    logic [2:0]            iss_frame;
    logic [WORD_IDX_W-1:0] iss_word;
    cfg_word_t             base;
    logic [2:0]            nframes;

    //////////////////////////////
    // buffer fetch
    //////////////////////////////

    // first fetch already in the start cycle, count not latched yet
    assign fetch_en = wr_start || fetching;
    assign nframes_eff = wr_start ? num_frames : nframes;
    assign f_last = (f_word == WORD_IDX_W'(WORDS_PER_FRAME - 1)) &&
                    (f_frame == nframes_eff - 3'd1);
    // pointer rests at zero between runs
    assign rd_addr = rd_ptr;

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fetching <= 1'b0;
            rd_ptr <= '0;
            f_frame <= '0;
            f_word <= '0;
        end
        else if (fetch_en)
        begin
            if (f_last)
            begin
                fetching <= 1'b0;
                rd_ptr <= '0;
                f_frame <= '0;
                f_word <= '0;
            end
            else
            begin
                fetching <= 1'b1;
                rd_ptr <= rd_ptr + 1'b1;
                if (f_word == WORD_IDX_W'(WORDS_PER_FRAME - 1))
                begin
                    f_word <= '0;
                    f_frame <= f_frame + 3'd1;
                end
                else
                    f_word <= f_word + 1'b1;
            end
        end
    end

    //////////////////////////////
    // write requests
    //////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            iss_valid <= 1'b0;
            iss_last <= 1'b0;
            iss_frame <= '0;
            iss_word <= '0;
            wr_done <= 1'b0;
        end
        else
        begin
            iss_valid <= fetch_en;
            iss_last <= fetch_en && f_last;
            iss_frame <= f_frame;
            iss_word <= f_word;
            // cycle after the last request
            wr_done <= iss_valid && iss_last;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (wr_start)
        begin
            base <= frame_addr;
            nframes <= num_frames;
        end
    end

    // buffer word arrives together with the delayed indices
    always_comb
    begin
        req = '0;
        req.valid = iss_valid;
        req.write = 1'b1;
        req.frame_addr = base + cfg_word_t'(iss_frame);
        req.word_idx = iss_word;
        req.data = rd_data;
    end

    // burst is over by wr_done, nothing left on the port
    a_quiet_at_done: assert property (@(posedge Clk) disable iff (!arst_n)
        wr_done |-> !req.valid);

endmodule

// ==== patch_sequencer.sv ====
`timescale 1ns/1ps

module patch_sequencer import cfg_pkg::*; (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  op_cmd_t               cmd,
    input  logic                  start,
    output logic                  rd_start,
    output logic                  wr_start,
    output cfg_word_t             op_frame_addr,
    output logic [2:0]            op_num_frames,
    input  cfg_req_t              rd_req,
    input  cfg_req_t              wr_req,
    output cfg_req_t              cfg_req,
    input  buf_wr_t               rd_buf_wr,
    output buf_wr_t               buf_wr,
    input  logic [BUF_ADDR_W-1:0] wr_rd_addr,
    output logic [BUF_ADDR_W-1:0] buf_rd_addr,
    input  cfg_word_t             buf_rd_data,
    input  logic                  rd_done,
    input  logic                  wr_done,
    output logic                  busy,
    output logic                  done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_FLIP_FETCH,
        S_FLIP_STORE,
        S_WRITE,
        S_FINISH
    } seq_state_t;

    seq_state_t            state;
    logic [1:0]            op_q;
    logic [BIT_LOC_W-1:0]  bit_loc_q;
    logic                  cmd_ok;
    logic                  accept;
    logic [WORD_IDX_W-1:0] flip_word;
    logic [4:0]            flip_bit;
    buf_wr_t               flip_wr;

    //////////////////////////////
    // command check
    //////////////////////////////

    assign cmd_ok = (cmd.op inside {OP_READ, OP_WRITE, OP_FLIP}) &&
                    (cmd.num_frames != 3'd0) &&
                    (cmd.num_frames <= 3'(MAX_FRAMES));
    // finish cycle already counts as not busy
    assign busy = (state != S_IDLE) && (state != S_FINISH);
    assign done = (state == S_FINISH);
    assign accept = start && cmd_ok && !busy;

    //////////////////////////////
    // operation FSM
    //////////////////////////////

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= S_IDLE;
            op_q <= '0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end
        else
        begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                S_IDLE, S_FINISH:
                begin
                    state <= S_IDLE;
                    if (accept)
                    begin
                        op_q <= cmd.op;
                        // read and flip both begin with a frame read
                        if (cmd.op == OP_WRITE)
                        begin
                            state <= S_WRITE;
                            wr_start <= 1'b1;
                        end
                        else
                        begin
                            state <= S_READ;
                            rd_start <= 1'b1;
                        end
                    end
                end
                S_READ:
                    if (rd_done)
                        state <= (op_q == OP_FLIP) ? S_FLIP_FETCH : S_FINISH;
                // word address on the buffer
                S_FLIP_FETCH:
                    state <= S_FLIP_STORE;
                // flipped word lands at the end of this cycle, writer starts after it
                S_FLIP_STORE:
                begin
                    state <= S_WRITE;
                    wr_start <= 1'b1;
                end
                S_WRITE:
                    if (wr_done)
                        state <= S_FINISH;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // command fields, flip is always one frame
    always_ff @(posedge Clk)
    begin
        if (accept)
        begin
            op_frame_addr <= cmd.frame_addr;
            op_num_frames <= (cmd.op == OP_FLIP) ? 3'd1 : cmd.num_frames;
            bit_loc_q <= cmd.bit_loc;
        end
    end

    //////////////////////////////
    // bit flip and steering
    //////////////////////////////

    // word index in upper bits, bit number in lower five
    assign flip_word = bit_loc_q[BIT_LOC_W-1:5];
    assign flip_bit = bit_loc_q[4:0];

    always_comb
    begin
        // single frame, so buffer address is the word index
        flip_wr.en = 1'b1;
        flip_wr.addr = BUF_ADDR_W'(flip_word);
        flip_wr.data = buf_rd_data ^ (cfg_word_t'(1) << flip_bit);

        case (state)
            S_READ:  cfg_req = rd_req;
            S_WRITE: cfg_req = wr_req;
            default: cfg_req = '0;
        endcase

        buf_wr = (state == S_FLIP_STORE) ? flip_wr : rd_buf_wr;
        buf_rd_addr = (state == S_FLIP_FETCH) ? BUF_ADDR_W'(flip_word) : wr_rd_addr;
    end

    // reader and writer share one port
    a_one_requester: assert property (@(posedge Clk) disable iff (!arst_n)
        !(rd_req.valid && wr_req.valid));

endmodule

// ==== frame_patch_top.sv ====
`timescale 1ns/1ps

module frame_patch_top import cfg_pkg::*; (
    input  logic     Clk,
    input  logic     arst_n,
    input  op_cmd_t  cmd,
    input  logic     start,
    input  cfg_rsp_t cfg_rsp,
    output cfg_req_t cfg_req,
    output logic     busy,
    output logic     done
);

    //////////////////////////////
    // internal wiring
    //////////////////////////////

    // sequencer to reader and writer
    logic                  rd_start;
    logic                  wr_start;
    cfg_word_t             op_frame_addr;
    logic [2:0]            op_num_frames;
    logic                  rd_done;
    logic                  wr_done;
    // port requests before steering
    cfg_req_t              rd_req;
    cfg_req_t              wr_req;
    // buffer ports
    buf_wr_t               rd_buf_wr;
    buf_wr_t               buf_wr;
    logic [BUF_ADDR_W-1:0] wr_rd_addr;
    logic [BUF_ADDR_W-1:0] buf_rd_addr;
    cfg_word_t             buf_rd_data;

    patch_sequencer u_seq (
        .Clk           (Clk),
        .arst_n        (arst_n),
        .cmd           (cmd),
        .start         (start),
        .rd_start      (rd_start),
        .wr_start      (wr_start),
        .op_frame_addr (op_frame_addr),
        .op_num_frames (op_num_frames),
        .rd_req        (rd_req),
        .wr_req        (wr_req),
        .cfg_req       (cfg_req),
        .rd_buf_wr     (rd_buf_wr),
        .buf_wr        (buf_wr),
        .wr_rd_addr    (wr_rd_addr),
        .buf_rd_addr   (buf_rd_addr),
        .buf_rd_data   (buf_rd_data),
        .rd_done       (rd_done),
        .wr_done       (wr_done),
        .busy          (busy),
        .done          (done)
    );

    // producer
    frame_reader u_reader (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .rd_start   (rd_start),
        .frame_addr (op_frame_addr),
        .num_frames (op_num_frames),
        .cfg_rsp    (cfg_rsp),
        .req        (rd_req),
        .buf_wr     (rd_buf_wr),
        .rd_done    (rd_done)
    );

    frame_buffer u_buf (
        .Clk     (Clk),
        .wr      (buf_wr),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    // consumer
    frame_writer u_writer (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .wr_start   (wr_start),
        .frame_addr (op_frame_addr),
        .num_frames (op_num_frames),
        .rd_addr    (wr_rd_addr),
        .rd_data    (buf_rd_data),
        .req        (wr_req),
        .wr_done    (wr_done)
    );

endmodule

// ==== tb_frame_patch_tests.svh ====
`ifndef TB_FRAME_PATCH_TESTS_SVH
`define TB_FRAME_PATCH_TESTS_SVH

// check kind per row
localparam int K_IDLE = 0;
localparam int K_READ = 1;
localparam int K_COPY = 2;
localparam int K_FLIP = 3;
localparam int K_RESTORE = 4;
localparam int K_BUSY = 5;
localparam int K_IGNORE = 6;
localparam int NUM_TESTS = 9;

// frame addresses used by the table
localparam cfg_word_t FRAME_A = 32'h0040_0000;
localparam cfg_word_t FRAME_B = 32'h0040_0100;
localparam cfg_word_t FRAME_C = 32'h0042_0040;
localparam cfg_word_t FRAME_D = 32'h0050_0000;
// word 37, bit 13
localparam logic [BIT_LOC_W-1:0] FLIP_LOC = 12'd1197;

typedef struct {
    string     name;
    op_cmd_t   cmd;
    int        kind;
    cfg_word_t ref_frame;
} test_row_t;

test_row_t rows [NUM_TESTS];

function automatic op_cmd_t make_cmd(input logic [1:0] op, input cfg_word_t frame,
                                     input logic [2:0] num, input logic [BIT_LOC_W-1:0] loc);
    op_cmd_t c;
    c.op = op;
    c.frame_addr = frame;
    c.num_frames = num;
    c.bit_loc = loc;
    return c;
endfunction

function void put_row(input int idx, input string name, input op_cmd_t c,
                      input int kind, input cfg_word_t ref_frame);
    rows[idx].name = name;
    rows[idx].cmd = c;
    rows[idx].kind = kind;
    rows[idx].ref_frame = ref_frame;
endfunction

//////////////////////////////
// stimulus table
//////////////////////////////

// ref_frame is the copy source, or the target of the start sent while busy
function void build_table();
    put_row(0, "idle_after_reset", make_cmd(2'd0, 32'h0, 3'd1, '0), K_IDLE, '0);
    put_row(1, "read_3_frames", make_cmd(OP_READ, FRAME_A, 3'd3, '0), K_READ, FRAME_A);
    put_row(2, "copy_3_frames", make_cmd(OP_WRITE, FRAME_B, 3'd3, '0), K_COPY, FRAME_A);
    // count 2 here, flip still moves one frame
    put_row(3, "flip_bit", make_cmd(OP_FLIP, FRAME_C, 3'd2, FLIP_LOC), K_FLIP, FRAME_C);
    put_row(4, "flip_bit_again", make_cmd(OP_FLIP, FRAME_C, 3'd1, FLIP_LOC), K_RESTORE,
            FRAME_C);
    put_row(5, "start_while_busy", make_cmd(OP_READ, FRAME_A, 3'd2, '0), K_BUSY, FRAME_D);
    put_row(6, "op_zero", make_cmd(2'd0, FRAME_D, 3'd1, '0), K_IGNORE, '0);
    put_row(7, "zero_frames", make_cmd(OP_READ, FRAME_D, 3'd0, '0), K_IGNORE, '0);
    put_row(8, "five_frames", make_cmd(OP_WRITE, FRAME_D, 3'd5, '0), K_IGNORE, '0);
endfunction

function automatic int cycle_budget(input int idx);
    return int'(rows[idx].cmd.num_frames) * WORDS_PER_FRAME + 50;
endfunction

task automatic pulse_start(input op_cmd_t c);
    @(negedge Clk);
    cmd = c;
    start = 1'b1;
    @(negedge Clk);
    start = 1'b0;
endtask

task automatic wait_done(input int max_cycles, output bit seen);
    seen = 1'b0;
    for (int k = 0; k < max_cycles && !seen; k++)
    begin
        @(posedge Clk);
        seen = (n_done != 0);
    end
endtask

//////////////////////////////
// table loop
//////////////////////////////

task automatic run_tests();
    op_cmd_t c;
    int      kind;
    int      err_start;
    int      n_words;
    bit      seen;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
        c = rows[t].cmd;
        kind = rows[t].kind;
        cur_name = rows[t].name;
        err_start = n_err;
        n_words = int'(c.num_frames) * WORDS_PER_FRAME;
        @(posedge Clk);
        clear_counts();
        if (kind == K_IDLE)
            repeat (20) @(posedge Clk);
        else if (kind == K_IGNORE)
        begin
            pulse_start(c);
            repeat (200) @(posedge Clk);
        end
        else
        begin
            pulse_start(c);
            // second start lands in the middle of the read
            if (kind == K_BUSY)
            begin
                repeat (5) @(negedge Clk);
                pulse_start(make_cmd(OP_WRITE, rows[t].ref_frame, 3'd1, '0));
            end
            wait_done(2 * cycle_budget(t), seen);
            if (!seen)
            begin
                $display("%s: done never arrived", cur_name);
                n_err++;
            end
            repeat ((kind == K_BUSY) ? 200 : 5) @(posedge Clk);
            compare_count("done pulses", 1, n_done);
        end

        if (n_bad != 0)
        begin
            $display("%s: request with word index past the frame end", cur_name);
            n_err++;
        end
        if (n_busy_err != 0)
        begin
            $display("%s: busy low during a request or still high with done", cur_name);
            n_err++;
        end
        case (kind)
            K_IDLE, K_IGNORE:
            begin
                if (n_rd + n_wr != 0)
                begin
                    $display("%s: unexpected config request, %0d seen", cur_name, n_rd + n_wr);
                    n_err++;
                end
                if (n_done != 0)
                begin
                    $display("%s: unexpected done pulse", cur_name);
                    n_err++;
                end
                compare_count("busy cycles", 0, n_busy);
            end
            K_READ, K_BUSY:
            begin
                compare_count("read requests", n_words, n_rd);
                compare_count("write requests", 0, n_wr);
            end
            K_COPY:
            begin
                compare_count("write requests", n_words, n_wr);
                compare_count("read requests", 0, n_rd);
                for (int f = 0; f < int'(c.num_frames); f++)
                    check_frame(c.frame_addr + f, rows[t].ref_frame + f, 0, '0);
            end
            default:
            begin
                // one frame each way, bit at word loc/32, position loc%32
                compare_count("read requests", WORDS_PER_FRAME, n_rd);
                compare_count("write requests", WORDS_PER_FRAME, n_wr);
                check_frame(c.frame_addr, c.frame_addr, int'(c.bit_loc) / 32,
                            (kind == K_FLIP) ? (32'd1 << (int'(c.bit_loc) % 32)) : '0);
                check_frame(c.frame_addr + 1, c.frame_addr + 1, 0, '0);
            end
        endcase

        if (n_err == err_start)
            $display("test %0d %s PASS", t, cur_name);
        else
        begin
            $display("test %0d %s FAIL", t, cur_name);
            n_fail++;
        end
    end
endtask

`endif

// ==== tb_frame_patch.sv ====
`timescale 1ns/1ps

module tb_frame_patch import cfg_pkg::*; ();

    // DUT ports
    logic     Clk;
    logic     arst_n;
    op_cmd_t  cmd;
    logic     start;
    cfg_rsp_t cfg_rsp = '0;
    cfg_req_t cfg_req;
    logic     busy;
    logic     done;

    // config memory model
    integer    seed;
    cfg_word_t seed_tab [WORDS_PER_FRAME];
    cfg_word_t written [logic [38:0]];
    cfg_rsp_t  rsp_pipe [CFG_READ_LATENCY];

    // per test activity counters
    int    n_rd = 0;
    int    n_wr = 0;
    int    n_done = 0;
    int    n_busy = 0;
    int    n_bad = 0;
    int    n_busy_err = 0;
    // run totals
    int    n_err = 0;
    int    n_fail = 0;
    string cur_name = "";
    bit    table_ready = 1'b0;

    frame_patch_top u_dut (
        .Clk     (Clk),
        .arst_n  (arst_n),
        .cmd     (cmd),
        .start   (start),
        .cfg_rsp (cfg_rsp),
        .cfg_req (cfg_req),
        .busy    (busy),
        .done    (done)
    );

    initial
    begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    //////////////////////////////
    // memory model
    //////////////////////////////

    // unwritten word, table value scrambled by the full frame address
    function automatic cfg_word_t seed_word(input cfg_word_t frame, input int w);
        return seed_tab[w] ^ (frame * 32'h9e37_79b1) ^ {frame[15:0], frame[31:16]};
    endfunction

    function automatic cfg_word_t model_word(input cfg_word_t frame, input int w);
        logic [38:0] key;
        key = {frame, WORD_IDX_W'(w)};
        if (written.exists(key))
            return written[key];
        return seed_word(frame, w);
    endfunction

    // outputs sampled mid cycle, response driven on the falling edge
    always @(negedge Clk)
    begin
        if (!arst_n)
        begin
            cfg_rsp <= '0;
            for (int i = 0; i < CFG_READ_LATENCY; i++)
                rsp_pipe[i] = '0;
        end
        else
        begin
            // oldest read leaves the pipe
            cfg_rsp <= rsp_pipe[CFG_READ_LATENCY-1];
            for (int i = CFG_READ_LATENCY - 1; i > 0; i--)
                rsp_pipe[i] = rsp_pipe[i-1];
            rsp_pipe[0] = '0;
            if (cfg_req.valid)
            begin
                if (cfg_req.word_idx >= WORD_IDX_W'(WORDS_PER_FRAME))
                    n_bad++;
                if (cfg_req.write)
                begin
                    written[{cfg_req.frame_addr, cfg_req.word_idx}] = cfg_req.data;
                    n_wr++;
                end
                else
                begin
                    rsp_pipe[0].valid = 1'b1;
                    rsp_pipe[0].data = model_word(cfg_req.frame_addr, int'(cfg_req.word_idx));
                    n_rd++;
                end
            end
            if (done)
                n_done++;
            if (busy)
                n_busy++;
            // busy covers every request and is already low with done
            if ((cfg_req.valid && !busy) || (done && busy))
                n_busy_err++;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    function void compare_count(input string what, input int exp_v, input int act_v);
        if (exp_v != act_v)
        begin
            $display("ERR %s %s expected %0d actual %0d", cur_name, what, exp_v, act_v);
            n_err++;
        end
    endfunction

    function void compare_word(input string what, input cfg_word_t exp_v,
                               input cfg_word_t act_v);
        if (exp_v !== act_v)
        begin
            $display("ERR %s %s expected %08h actual %08h", cur_name, what, exp_v, act_v);
            n_err++;
        end
    endfunction

    // whole frame against the seed of ref_frame, one word optionally flipped
    function void check_frame(input cfg_word_t frame, input cfg_word_t ref_frame,
                              input int flip_w, input cfg_word_t mask);
        cfg_word_t exp_w;
        for (int w = 0; w < WORDS_PER_FRAME; w++)
        begin
            exp_w = seed_word(ref_frame, w);
            if (w == flip_w)
                exp_w = exp_w ^ mask;
            compare_word($sformatf("frame %08h word %0d", frame, w), exp_w,
                         model_word(frame, w));
        end
    endfunction

    function void clear_counts();
        n_rd = 0;
        n_wr = 0;
        n_done = 0;
        n_busy = 0;
        n_bad = 0;
        n_busy_err = 0;
    endfunction

    `include "tb_frame_patch_tests.svh"

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        arst_n = 1'b0;
        start = 1'b0;
        cmd = '0;
        seed = 21;
        for (int w = 0; w < WORDS_PER_FRAME; w++)
            seed_tab[w] = $random(seed);
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge Clk);
        @(negedge Clk);
        arst_n = 1'b1;
        run_tests();
        $display("tests %0d, failed %0d, failed checks %0d", NUM_TESTS, n_fail, n_err);
        if (n_err == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // twice the summed budget of all rows
    initial
    begin
        int limit;
        wait (table_ready);
        limit = 0;
        for (int i = 0; i < NUM_TESTS; i++)
            limit += cycle_budget(i);
        limit = limit * 2;
        repeat (limit) @(posedge Clk);
        $display("watchdog expired, run still going after %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== frame_patch_top.f ====
+incdir+.
cfg_pkg.sv
frame_reader.sv
frame_buffer.sv
frame_writer.sv
patch_sequencer.sv
frame_patch_top.sv
tb_frame_patch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame patch testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frame_patch -f frame_patch_top.f -o tb_frame_patch_sim \
    && ./obj_dir/tb_frame_patch_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
